//--- verilog.f
+incdir+tests
design/rob_pkg.sv
design/rob_dispatch.sv
design/rob_buffer.sv
design/rob_retire.sv
design/arch_map_table.sv
design/rob_top.sv
tests/rob_tb.sv

//--- tests/rob_tb_tasks.svh
//////////////////////////////////////////////////
// Random source and compare helpers
//////////////////////////////////////////////////

// 32-bit xorshift, state kept in rng
function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
        $display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                           input logic [CNT_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_idx(input string name, input logic [IDX_W-1:0] got,
                         input logic [IDX_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    n_checks++;
    if (got !== exp) begin
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_phys(input string name, input phys_tag_t got, input phys_tag_t exp);
    n_checks++;
    if (got !== exp) begin
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        err_count++;
    end
endtask

//////////////////////////////////////////////////
// Drive and wait helpers
//////////////////////////////////////////////////

// Reset for two cycles, model back to empty and identity map
task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    ref_q.delete();
    ref_tail = 0;
    for (int r = 0; r < ARCH_REG_SZ; r++) begin
        ref_map[r] = phys_tag_t'(r);
    end
endtask

// Offer the first n staged entries, holding lanes until counted
task automatic dispatch_lanes(input int n);
    int k;
    int tries;
    int c;
    ref_entry_t e;
    k = 0;
    tries = 0;
    while (k < n && tries < 100) begin
        @(negedge clock);
        disp_valid = '0;
        for (int i = 0; i < N; i++) begin
            if (k + i < n) begin
                disp_valid[i] = 1'b1;
                disp_rd[i]    = st_rd[k + i];
                disp_phys[i]  = st_phys[k + i];
                disp_told[i]  = st_told[k + i];
            end
        end
        #1;
        c = int'(disp_count);
        // Lanes taken while a bad branch retires are wrong path and vanish
        if (!flush_now) begin
            for (int i = 0; i < c; i++) begin
                check_idx("disp_idx", disp_idx[i], IDX_W'((ref_tail + i) % ROB_SZ));
                e.rd   = st_rd[k + i];
                e.phys = st_phys[k + i];
                e.told = st_told[k + i];
                e.idx  = (ref_tail + i) % ROB_SZ;
                e.done = 1'b0;
                e.mis  = 1'b0;
                ref_q.push_back(e);
            end
            ref_tail = (ref_tail + c) % ROB_SZ;
        end
        k = k + c;
        tries++;
    end
    @(negedge clock);
    disp_valid = '0;
    if (k < n) begin
        $display("Dispatch timed out with %0d of %0d entries accepted", k, n);
        err_count++;
    end
endtask

// Complete one entry, model marked after the edge
// Lane follows the slot index so both completion ports see traffic
task automatic complete_entry(input int idx, input logic mis);
    int lane;
    lane = idx % N;
    @(negedge clock);
    cmpl_valid[lane]   = 1'b1;
    cmpl_idx[lane]     = IDX_W'(idx);
    cmpl_mispred[lane] = mis;
    @(posedge clock);
    #1;
    foreach (ref_q[j]) begin
        if (ref_q[j].idx == idx && !ref_q[j].done) begin
            ref_q[j].done = 1'b1;
            ref_q[j].mis  = mis;
        end
    end
    @(negedge clock);
    cmpl_valid   = '0;
    cmpl_mispred = '0;
endtask

// Complete every entry still waiting, oldest first
task automatic complete_pending();
    int idxs[$];
    @(posedge clock);
    #1;
    foreach (ref_q[j]) begin
        if (!ref_q[j].done) begin
            idxs.push_back(ref_q[j].idx);
        end
    end
    foreach (idxs[k]) begin
        complete_entry(idxs[k], 1'b0);
    end
endtask

task automatic wait_commits(input int target);
    int tries;
    tries = 0;
    while (commit_total < target && tries < 200) begin
        @(posedge clock);
        #1;
        tries++;
    end
    if (commit_total < target) begin
        $display("Timed out waiting for commits, %0d of %0d seen", commit_total, target);
        err_count++;
    end
endtask

task automatic check_arch(input int idx, input phys_tag_t exp);
    @(negedge clock);
    arch_read_idx = reg_idx_t'(idx);
    #1;
    check_phys("arch_read_phys", arch_read_phys, exp);
endtask

task automatic report_test(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, err_count - errs_before);
endtask

//--- tests/rob_tb.sv
`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

    localparam int N = 2;
    localparam int ROB_SZ = 8;
    localparam int IDX_W = $clog2(ROB_SZ);
    localparam int CNT_W = $clog2(N + 1);

    logic                    clock;
    logic                    reset;
    logic [N-1:0]            disp_valid;
    reg_idx_t [N-1:0]        disp_rd;
    phys_tag_t [N-1:0]       disp_phys;
    phys_tag_t [N-1:0]       disp_told;
    logic [CNT_W-1:0]        disp_count;
    logic [N-1:0][IDX_W-1:0] disp_idx;
    logic [N-1:0]            cmpl_valid;
    logic [N-1:0][IDX_W-1:0] cmpl_idx;
    logic [N-1:0]            cmpl_mispred;
    logic [N-1:0]            commit_valid;
    reg_idx_t [N-1:0]        commit_rd;
    phys_tag_t [N-1:0]       commit_phys;
    phys_tag_t [N-1:0]       commit_told;
    logic                    mispredict;
    reg_idx_t                arch_read_idx;
    phys_tag_t               arch_read_phys;

    // Reference entry, in program order
    typedef struct {
        reg_idx_t  rd;
        phys_tag_t phys;
        phys_tag_t told;
        int        idx;
        bit        done;
        bit        mis;
    } ref_entry_t;

    ref_entry_t  ref_q[$];
    phys_tag_t   ref_map [ARCH_REG_SZ];
    int          err_count;
    int          n_checks;
    int          commit_total;
    int          mis_total;
    logic [31:0] rng;

    // Next slot the model expects dispatch to fill
    int          ref_tail;

    // Model expects a bad branch to retire this cycle
    bit          flush_now;

    // Staged dispatch lanes
    reg_idx_t    st_rd [N];
    phys_tag_t   st_phys [N];
    phys_tag_t   st_told [N];

    `include "rob_tb_tasks.svh"

    rob_top #(.N(N), .ROB_SZ(ROB_SZ)) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Commit monitor
    //////////////////////////////////////////////////

    // Head state only changes at the rising edge
    always @(negedge clock) begin
        logic exp_mis;
        logic dropped;
        ref_entry_t head;
        exp_mis = 1'b0;
        dropped = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (commit_valid[i] === 1'b1) begin
                if (dropped || ref_q.size() == 0) begin
                    $display("Commit on lane %0d at %0t with no live entry", i, $time);
                    err_count++;
                end else begin
                    head = ref_q.pop_front();
                    if (!head.done) begin
                        $display("Entry %0d committed before it completed", head.idx);
                        err_count++;
                    end
                    check_reg("commit_rd", commit_rd[i], head.rd);
                    check_phys("commit_phys", commit_phys[i], head.phys);
                    check_phys("commit_told", commit_told[i], head.told);
                    commit_total++;
                    if (head.rd != '0) begin
                        ref_map[head.rd] = head.phys;
                    end
                    // Bad branch drops everything younger
                    if (head.mis) begin
                        exp_mis = 1'b1;
                        dropped = 1'b1;
                        mis_total++;
                        ref_q.delete();
                        ref_tail = 0;
                    end
                end
            end
        end
        flush_now = exp_mis;
        check_bit("mispredict", mispredict, exp_mis);
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        int errs;
        errs = err_count;
        @(negedge clock);
        disp_valid = 2'b11;
        #1;
        check_count("disp_count", disp_count, 2);
        check_idx("disp_idx[0]", disp_idx[0], 0);
        check_idx("disp_idx[1]", disp_idx[1], 1);
        check_bit("commit_valid[0]", commit_valid[0], 1'b0);
        check_bit("commit_valid[1]", commit_valid[1], 1'b0);
        disp_valid = '0;
        for (int r = 0; r < ARCH_REG_SZ; r++) begin
            check_arch(r, phys_tag_t'(r));
        end
        report_test("reset", errs);
    endtask

    task automatic test_in_order();
        int errs;
        int base;
        int idx [4];
        errs = err_count;
        base = commit_total;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < N; i++) begin
                st_rd[i]   = reg_idx_t'(1 + 2 * p + i);
                st_phys[i] = phys_tag_t'(33 + 2 * p + i);
                st_told[i] = phys_tag_t'(1 + 2 * p + i);
            end
            dispatch_lanes(2);
        end
        for (int k = 0; k < 4; k++) begin
            idx[k] = ref_q[k].idx;
        end
        // Youngest first, the head stays blocked
        complete_entry(idx[3], 1'b0);
        complete_entry(idx[2], 1'b0);
        complete_entry(idx[1], 1'b0);
        repeat (2) @(posedge clock);
        if (commit_total != base) begin
            $display("Commit seen while the oldest entry was still incomplete");
            err_count++;
        end
        complete_entry(idx[0], 1'b0);
        wait_commits(base + 4);
        report_test("in-order retire", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        int base;
        errs = err_count;
        apply_reset();
        base = commit_total;
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < N; i++) begin
                st_rd[i]   = reg_idx_t'(11 + 2 * p + i);
                st_phys[i] = phys_tag_t'(50 + 2 * p + i);
                st_told[i] = phys_tag_t'(11 + 2 * p + i);
            end
            dispatch_lanes(2);
        end
        @(negedge clock);
        disp_valid = 2'b11;
        #1;
        check_count("disp_count", disp_count, 0);
        disp_valid = '0;
        complete_entry(ref_q[0].idx, 1'b0);
        wait_commits(base + 1);
        @(negedge clock);
        disp_valid = 2'b11;
        #1;
        check_count("disp_count", disp_count, 1);
        check_idx("disp_idx[0]", disp_idx[0], 0);
        disp_valid = '0;
        complete_pending();
        wait_commits(base + 8);
        report_test("back-pressure", errs);
    endtask

    task automatic test_mispredict();
        int errs;
        int base;
        int mis_base;
        int idx [4];
        errs = err_count;
        base = commit_total;
        mis_base = mis_total;
        // A, B (branch), C, D
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < N; i++) begin
                st_rd[i]   = reg_idx_t'(5 + 2 * p + i);
                st_phys[i] = phys_tag_t'(45 + 2 * p + i);
                st_told[i] = phys_tag_t'(5 + 2 * p + i);
            end
            dispatch_lanes(2);
        end
        for (int k = 0; k < 4; k++) begin
            idx[k] = ref_q[k].idx;
        end
        complete_entry(idx[2], 1'b0);
        complete_entry(idx[3], 1'b0);
        complete_entry(idx[0], 1'b0);
        wait_commits(base + 1);
        complete_entry(idx[1], 1'b1);
        wait_commits(base + 2);
        repeat (4) @(posedge clock);
        #1;
        if (commit_total != base + 2 || mis_total != mis_base + 1) begin
            $display("Flush did not drop the younger entries as expected");
            err_count++;
        end
        @(negedge clock);
        #1;
        check_idx("disp_idx[0]", disp_idx[0], 0);
        report_test("mispredict flush", errs);
    endtask

    task automatic test_arch_map();
        int errs;
        int base;
        errs = err_count;
        base = commit_total;
        // Same register on both lanes
        st_rd[0] = 9;
        st_phys[0] = 40;
        st_told[0] = 9;
        st_rd[1] = 9;
        st_phys[1] = 41;
        st_told[1] = 40;
        dispatch_lanes(2);
        st_rd[0] = 0;
        st_phys[0] = 42;
        st_told[0] = 0;
        st_rd[1] = 10;
        st_phys[1] = 43;
        st_told[1] = 10;
        dispatch_lanes(2);
        complete_entry(1, 1'b0);
        complete_entry(0, 1'b0);
        complete_entry(3, 1'b0);
        complete_entry(2, 1'b0);
        wait_commits(base + 4);
        check_arch(9, 41);
        check_arch(10, 43);
        check_arch(0, 0);
        report_test("architectural map", errs);
    endtask

    task automatic test_random();
        int errs;
        int n;
        int pick;
        int open [$];
        logic [31:0] r;
        errs = err_count;
        for (int cyc = 0; cyc < 200; cyc++) begin
            @(posedge clock);
            #1;
            r = xorshift();
            n = 1 + int'(r[1]);
            if (r[0] && ref_q.size() + n <= ROB_SZ) begin
                for (int i = 0; i < N; i++) begin
                    r = xorshift();
                    st_rd[i]   = r[4:0];
                    st_phys[i] = r[10:5];
                    st_told[i] = r[16:11];
                end
                dispatch_lanes(n);
            end else begin
                open.delete();
                foreach (ref_q[j]) begin
                    if (!ref_q[j].done) begin
                        open.push_back(ref_q[j].idx);
                    end
                end
                if (open.size() > 0) begin
                    pick = int'(r[15:8]) % open.size();
                    complete_entry(open[pick], r[20:17] == 4'h0);
                end
            end
        end
        for (int t = 0; t < 20 && ref_q.size() > 0; t++) begin
            complete_pending();
            repeat (4) @(posedge clock);
            #1;
        end
        if (ref_q.size() != 0) begin
            $display("Buffer did not drain, %0d entries left", ref_q.size());
            err_count++;
        end
        for (int reg_i = 0; reg_i < ARCH_REG_SZ; reg_i++) begin
            check_arch(reg_i, ref_map[reg_i]);
        end
        report_test("random mix", errs);
    endtask

    initial begin
        rng = 32'h4481;
        err_count = 0;
        n_checks = 0;
        commit_total = 0;
        mis_total = 0;
        ref_tail = 0;
        flush_now = 1'b0;
        disp_valid = '0;
        disp_rd = '0;
        disp_phys = '0;
        disp_told = '0;
        cmpl_valid = '0;
        cmpl_idx = '0;
        cmpl_mispred = '0;
        arch_read_idx = '0;
        apply_reset();
        test_reset();
        test_in_order();
        test_backpressure();
        test_mispredict();
        test_arch_map();
        test_random();
        $display("Checks run %0d, errors %0d", n_checks, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- design/rob_top.sv
`timescale 1ns/1ps

module rob_top import rob_pkg::*; #(
    parameter int N = DEF_N,
    parameter int ROB_SZ = DEF_ROB_SZ,
    localparam int IDX_W = (ROB_SZ > 1) ? $clog2(ROB_SZ) : 1,
    localparam int CNT_W = $clog2(N + 1)
) (
    input  logic                    clock,
    input  logic                    reset,

    // Dispatch side
    input  logic [N-1:0]            disp_valid,
    input  reg_idx_t [N-1:0]        disp_rd,
    input  phys_tag_t [N-1:0]       disp_phys,
    input  phys_tag_t [N-1:0]       disp_told,
    output logic [CNT_W-1:0]        disp_count,
    output logic [N-1:0][IDX_W-1:0] disp_idx,

    // Completion side
    input  logic [N-1:0]            cmpl_valid,
    input  logic [N-1:0][IDX_W-1:0] cmpl_idx,
    input  logic [N-1:0]            cmpl_mispred,

    // Commit side
    output logic [N-1:0]            commit_valid,
    output reg_idx_t [N-1:0]        commit_rd,
    output phys_tag_t [N-1:0]       commit_phys,
    output phys_tag_t [N-1:0]       commit_told,
    output logic                    mispredict,

    // Architectural map lookup
    input  reg_idx_t                arch_read_idx,
    output phys_tag_t               arch_read_phys
);

    //////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////

    logic [$clog2(ROB_SZ + 1)-1:0] free_slots;
    logic [N-1:0]                  alloc_valid;

    // Head window
    rob_entry_t [N-1:0]            head_entries;
    logic [N-1:0]                  head_occupied;
    logic [CNT_W-1:0]              retire_count;
    logic                          flush;

    // Retire into the map table
    logic [N-1:0]                  arch_we;
    reg_idx_t [N-1:0]              arch_rd;
    phys_tag_t [N-1:0]             arch_phys;

    //////////////////////////////////////////////////
    // Producer, buffer, consumer
    //////////////////////////////////////////////////

    rob_dispatch #(.N(N), .ROB_SZ(ROB_SZ)) i_dispatch (
        .disp_valid  (disp_valid),
        .free_slots  (free_slots),
        .disp_count  (disp_count),
        .alloc_valid (alloc_valid)
    );

    rob_buffer #(.N(N), .ROB_SZ(ROB_SZ)) i_buffer (
        .clock         (clock),
        .reset         (reset),
        .alloc_valid   (alloc_valid),
        .disp_rd       (disp_rd),
        .disp_phys     (disp_phys),
        .disp_told     (disp_told),
        .cmpl_valid    (cmpl_valid),
        .cmpl_idx      (cmpl_idx),
        .cmpl_mispred  (cmpl_mispred),
        .retire_count  (retire_count),
        .flush         (flush),
        .free_slots    (free_slots),
        .alloc_idxs    (disp_idx),
        .head_entries  (head_entries),
        .head_occupied (head_occupied)
    );

    rob_retire #(.N(N)) i_retire (
        .head_entries  (head_entries),
        .head_occupied (head_occupied),
        .retire_count  (retire_count),
        .flush         (flush),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_phys   (commit_phys),
        .commit_told   (commit_told),
        .mispredict    (mispredict),
        .arch_we       (arch_we),
        .arch_rd       (arch_rd),
        .arch_phys     (arch_phys)
    );

    // Retire target
    arch_map_table #(.N(N)) i_arch_map (
        .clock          (clock),
        .reset          (reset),
        .arch_we        (arch_we),
        .arch_rd        (arch_rd),
        .arch_phys      (arch_phys),
        .arch_read_idx  (arch_read_idx),
        .arch_read_phys (arch_read_phys)
    );

endmodule

//--- design/arch_map_table.sv
`timescale 1ns/1ps

module arch_map_table import rob_pkg::*; #(
    parameter int N = DEF_N
) (
    input  logic              clock,
    input  logic              reset,

    // Retire write ports, lane 0 oldest
    input  logic [N-1:0]      arch_we,
    input  reg_idx_t [N-1:0]  arch_rd,
    input  phys_tag_t [N-1:0] arch_phys,

    // Combinational read port
    input  reg_idx_t          arch_read_idx,
    output phys_tag_t         arch_read_phys
);

    // Committed mapping of each architectural register
    phys_tag_t map_q [ARCH_REG_SZ];

    //////////////////////////////////////////////////
    // Table update
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map out of reset
            for (int r = 0; r < ARCH_REG_SZ; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
        end else begin
            // Lane order, so the younger write lands last
            for (int i = 0; i < N; i++) begin
                if (arch_we[i]) begin
                    map_q[arch_rd[i]] <= arch_phys[i];
                end
            end
        end
    end

    assign arch_read_phys = map_q[arch_read_idx];

endmodule

//--- design/rob_retire.sv
`timescale 1ns/1ps

module rob_retire import rob_pkg::*; #(
    parameter int N = DEF_N,
    localparam int CNT_W = $clog2(N + 1)
) (
    // Head window from the ROB, lane 0 oldest
    input  rob_entry_t [N-1:0] head_entries,
    input  logic [N-1:0]       head_occupied,

    // Back to the ROB
    output logic [CNT_W-1:0]   retire_count,
    output logic               flush,

    // Commit report per lane
    output logic [N-1:0]       commit_valid,
    output reg_idx_t [N-1:0]   commit_rd,
    output phys_tag_t [N-1:0]  commit_phys,
    output phys_tag_t [N-1:0]  commit_told,
    output logic               mispredict,

    // Write ports of the architectural map
    output logic [N-1:0]       arch_we,
    output reg_idx_t [N-1:0]   arch_rd,
    output phys_tag_t [N-1:0]  arch_phys
);

    // Older lanes all retire and none is a bad branch
    logic             lane_open;
    logic [CNT_W-1:0] n_retire;

    //////////////////////////////////////////////////
    // In-order prefix
    //////////////////////////////////////////////////

    always_comb begin
        lane_open  = 1'b1;
        n_retire   = '0;
        mispredict = 1'b0;
        for (int i = 0; i < N; i++) begin
            commit_valid[i] = lane_open && head_occupied[i] && head_entries[i].complete;
            if (commit_valid[i]) begin
                n_retire = n_retire + CNT_W'(1);
                // Branch itself commits, everything younger is dropped
                if (head_entries[i].mispred) begin
                    mispredict = 1'b1;
                end
            end
            lane_open = commit_valid[i] && !head_entries[i].mispred;
        end
    end

    assign retire_count = n_retire;

    // Whole buffer is wrong path behind a retiring mispredict
    assign flush = mispredict;

    //////////////////////////////////////////////////
    // Commit payload
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            commit_rd[i]   = head_entries[i].rd;
            commit_phys[i] = head_entries[i].phys;
            commit_told[i] = head_entries[i].told;
        end
    end

    // x0 never gets a new mapping
    // Same-register writes are ordered by lane in the table
    always_comb begin
        for (int i = 0; i < N; i++) begin
            arch_we[i]   = commit_valid[i] && (head_entries[i].rd != '0);
            arch_rd[i]   = head_entries[i].rd;
            arch_phys[i] = head_entries[i].phys;
        end
    end

endmodule

//--- design/rob_buffer.sv
`timescale 1ns/1ps

module rob_buffer import rob_pkg::*; #(
    parameter int N = DEF_N,
    parameter int ROB_SZ = DEF_ROB_SZ,
    localparam int IDX_W = (ROB_SZ > 1) ? $clog2(ROB_SZ) : 1,
    localparam int CNT_W = $clog2(N + 1),
    localparam int FREE_W = $clog2(ROB_SZ + 1)
) (
    input  logic                       clock,
    input  logic                       reset,

    // Allocation from dispatch
    input  logic [N-1:0]               alloc_valid,
    input  reg_idx_t [N-1:0]           disp_rd,
    input  phys_tag_t [N-1:0]          disp_phys,
    input  phys_tag_t [N-1:0]          disp_told,

    // Completion, any order
    input  logic [N-1:0]               cmpl_valid,
    input  logic [N-1:0][IDX_W-1:0]    cmpl_idx,
    input  logic [N-1:0]               cmpl_mispred,

    // From retire
    input  logic [CNT_W-1:0]           retire_count,
    input  logic                       flush,

    // To dispatch
    output logic [FREE_W-1:0]          free_slots,
    output logic [N-1:0][IDX_W-1:0]    alloc_idxs,

    // Head window, lane 0 is the oldest entry
    output rob_entry_t [N-1:0]         head_entries,
    output logic [N-1:0]               head_occupied
);

    // Entry storage, occupancy comes from head and count
    rob_entry_t        entries [ROB_SZ];

    logic [IDX_W-1:0]  head_q;
    logic [IDX_W-1:0]  tail_q;
    logic [FREE_W-1:0] count_q;

    // Number of lanes written this cycle
    logic [FREE_W-1:0] n_alloc;

    // Slot index of each head lane
    logic [N-1:0][IDX_W-1:0] head_idxs;

    // Circular add, also covers a single-entry buffer
    function automatic logic [IDX_W-1:0] wrap(input logic [IDX_W-1:0] base,
                                              input int unsigned off);
        wrap = IDX_W'((int'(base) + off) % ROB_SZ);
    endfunction

    //////////////////////////////////////////////////
    // Index and count views
    //////////////////////////////////////////////////

    assign free_slots = FREE_W'(ROB_SZ) - count_q;

    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < N; i++) begin
            n_alloc = n_alloc + FREE_W'(alloc_valid[i]);
        end
    end

    // Slots the lanes would land in, valid or not
    always_comb begin
        for (int i = 0; i < N; i++) begin
            alloc_idxs[i] = wrap(tail_q, i);
            head_idxs[i]  = wrap(head_q, i);
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            head_entries[i]  = entries[head_idxs[i]];
            head_occupied[i] = (FREE_W'(i) < count_q);
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            // Mispredict empties the whole buffer
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= wrap(head_q, int'(retire_count));
            tail_q  <= wrap(tail_q, int'(n_alloc));
            count_q <= count_q + n_alloc - FREE_W'(retire_count);
        end
    end

    //////////////////////////////////////////////////
    // Entry writes
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        // Completion marks an occupied slot
        for (int i = 0; i < N; i++) begin
            if (cmpl_valid[i]) begin
                entries[cmpl_idx[i]].complete <= 1'b1;
                entries[cmpl_idx[i]].mispred  <= cmpl_mispred[i];
            end
        end
        // New entries start incomplete
        // Free slots never take a completion, so no overlap
        for (int i = 0; i < N; i++) begin
            if (alloc_valid[i]) begin
                entries[alloc_idxs[i]].rd       <= disp_rd[i];
                entries[alloc_idxs[i]].phys     <= disp_phys[i];
                entries[alloc_idxs[i]].told     <= disp_told[i];
                entries[alloc_idxs[i]].complete <= 1'b0;
                entries[alloc_idxs[i]].mispred  <= 1'b0;
            end
        end
    end

endmodule

//--- design/rob_dispatch.sv
`timescale 1ns/1ps

module rob_dispatch import rob_pkg::*; #(
    parameter int N = DEF_N,
    parameter int ROB_SZ = DEF_ROB_SZ,
    localparam int CNT_W = $clog2(N + 1),
    localparam int FREE_W = $clog2(ROB_SZ + 1)
) (
    // Lane valids from the front end, lane 0 oldest
    input  logic [N-1:0]      disp_valid,

    // Empty slots in the ROB this cycle
    input  logic [FREE_W-1:0] free_slots,

    // Lanes accepted this cycle
    output logic [CNT_W-1:0]  disp_count,

    // Per-lane write enables into the ROB
    output logic [N-1:0]      alloc_valid
);

    // Length of the leading run of valid lanes
    logic [CNT_W-1:0]  run_len;
    logic              run_open;

    // Run length widened for the compare against free slots
    logic [FREE_W-1:0] run_wide;

    //////////////////////////////////////////////////
    // Leading run of valid lanes
    //////////////////////////////////////////////////

    always_comb begin
        run_len  = '0;
        run_open = 1'b1;
        for (int i = 0; i < N; i++) begin
            // First hole ends the run, later lanes must wait
            if (run_open && disp_valid[i]) begin
                run_len = run_len + CNT_W'(1);
            end else begin
                run_open = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Clamp to free slots
    //////////////////////////////////////////////////

    assign run_wide = FREE_W'(run_len);

    always_comb begin
        // ROB_SZ >= N, so a clamped count still fits in CNT_W
        if (run_wide <= free_slots) begin
            disp_count = run_len;
        end else begin
            disp_count = CNT_W'(free_slots);
        end
    end

    // Accepted lanes are always a prefix starting at lane 0
    always_comb begin
        for (int i = 0; i < N; i++) begin
            alloc_valid[i] = (CNT_W'(i) < disp_count);
        end
    end

endmodule

//--- design/rob_pkg.sv
package rob_pkg;

    //////////////////////////////////////////////////
    // Register file sizes
    //////////////////////////////////////////////////

    // Architectural registers, x0 hard-wired to zero
    localparam int ARCH_REG_SZ = 32;

    // Physical registers behind the rename stage
    localparam int PHYS_REG_SZ = 64;

    // Architectural register index
    typedef logic [$clog2(ARCH_REG_SZ)-1:0] reg_idx_t;

    // Physical register tag
    typedef logic [$clog2(PHYS_REG_SZ)-1:0] phys_tag_t;

    //////////////////////////////////////////////////
    // Reorder buffer entry
    //////////////////////////////////////////////////

    // One slot of the ROB
    // told is the mapping that rd had before this instruction renamed it
    typedef struct packed {
        reg_idx_t  rd;
        phys_tag_t phys;
        phys_tag_t told;
        logic      complete;
        logic      mispred;
    } rob_entry_t;

    //////////////////////////////////////////////////
    // Default sizes
    //////////////////////////////////////////////////

    // Dispatch and retire lanes per cycle
    localparam int DEF_N = 2;

    // ROB entries, power of two
    localparam int DEF_ROB_SZ = 8;

endpackage
